// ==== design/brb_pkg.sv ====
package brb_pkg;

    // ====================
    // Lane count and widths
    // ====================

    // Parallel decode, execute and resolve lanes
    localparam int LANES = 3;

    // ROB id tag width
    localparam int ROB_ID_W = 6;

    // Program counter width
    localparam int PC_W = 32;

    // ====================
    // Lane structs
    // ====================

    // One decode push
    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] rob_id;
    } push_lane_t;

    // One execute result
    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] rob_id;
        logic                mispredict;
        logic [PC_W-1:0]     pc;
    } exec_lane_t;

    // One in-order resolution that reads all zeros when not reported
    typedef struct packed {
        logic                resolved;
        logic                mispredict;
        logic [ROB_ID_W-1:0] rob_id;
        logic [PC_W-1:0]     pc;
    } resolve_lane_t;

    // One oldest-window slot as read from storage
    typedef struct packed {
        logic                present;
        logic [ROB_ID_W-1:0] rob_id;
        logic                resolved;
        logic                mispredict;
        logic [PC_W-1:0]     pc;
    } win_entry_t;

endpackage

// ==== design/brb_ptr_ctrl.sv ====
`timescale 1ns/1ns

module brb_ptr_ctrl
    import brb_pkg::*;
#(
    parameter int BUF_DEPTH = 16
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  push_lane_t [LANES-1:0]                push,
    input  logic [1:0]                            pop_count,
    input  logic                                  flush_req,
    input  logic                                  flush,
    output logic [$clog2(BUF_DEPTH)-1:0]          head_idx,
    output logic [LANES-1:0]                      wr_en,
    output logic [LANES-1:0][$clog2(BUF_DEPTH)-1:0] wr_slot,
    output logic [$clog2(BUF_DEPTH):0]            count,
    output logic                                  full,
    output logic                                  empty
);

    localparam int IDX_W = $clog2(BUF_DEPTH);
    // Pointer and count carry one extra wrap bit
    localparam int PTR_W = IDX_W + 1;

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [PTR_W-1:0] free_slots;
    logic [1:0]       push_num;
    logic             flush_any;
    logic             accept;

    // ====================
    // Occupancy
    // ====================

    // Wrap bit makes the plain difference the occupancy
    assign count      = tail_ptr - head_ptr;
    assign free_slots = PTR_W'(BUF_DEPTH) - count;
    assign full       = (count == PTR_W'(BUF_DEPTH));
    assign empty      = (count == '0);
    assign head_idx   = head_ptr[IDX_W-1:0];

    // Mispredict from the resolver or the external flush
    assign flush_any = flush_req | flush;

    // ====================
    // Push slot assignment
    // ====================

    // Valid lanes take consecutive slots, invalid lanes are skipped
    always_comb begin
        push_num = '0;
        for (int i = 0; i < LANES; i++) begin
            wr_slot[i] = tail_ptr[IDX_W-1:0] + IDX_W'(push_num);
            push_num   = push_num + {1'b0, push[i].valid};
        end
    end

    // Whole group goes in or nothing does
    assign accept = (PTR_W'(push_num) <= free_slots) && !flush_any;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            wr_en[i] = accept && push[i].valid;
        end
    end

    // Pointer update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else if (flush_any) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            // Only correctly predicted reports retire
            head_ptr <= head_ptr + PTR_W'(pop_count);
            if (accept) begin
                tail_ptr <= tail_ptr + PTR_W'(push_num);
            end
        end
    end

endmodule

// ==== design/brb_entry_store.sv ====
`timescale 1ns/1ns

module brb_entry_store
    import brb_pkg::*;
#(
    parameter int BUF_DEPTH = 16
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  push_lane_t [LANES-1:0]                  push,
    input  logic [LANES-1:0]                        wr_en,
    input  logic [LANES-1:0][$clog2(BUF_DEPTH)-1:0] wr_slot,
    input  exec_lane_t [LANES-1:0]                  exec,
    input  logic                                    flush_all,
    input  logic [$clog2(BUF_DEPTH)-1:0]            head_idx,
    input  logic [$clog2(BUF_DEPTH):0]              count,
    output win_entry_t [LANES-1:0]                  window
);

    localparam int IDX_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = IDX_W + 1;

    // ====================
    // Entry arrays
    // ====================

    logic [ROB_ID_W-1:0] rob_id_mem [BUF_DEPTH];
    logic [PC_W-1:0]     pc_mem [BUF_DEPTH];
    logic [BUF_DEPTH-1:0] resolved_mem;
    logic [BUF_DEPTH-1:0] mispred_mem;

    // Per-entry winning execute result
    logic [BUF_DEPTH-1:0] hit;
    logic [BUF_DEPTH-1:0] hit_mis;
    logic [PC_W-1:0]      hit_pc [BUF_DEPTH];

    // Scan lanes from the top down so lane 0 lands last and wins
    always_comb begin
        for (int e = 0; e < BUF_DEPTH; e++) begin
            hit[e]     = 1'b0;
            hit_mis[e] = 1'b0;
            hit_pc[e]  = '0;
            for (int l = LANES - 1; l >= 0; l--) begin
                if (exec[l].valid && (exec[l].rob_id == rob_id_mem[e])) begin
                    hit[e]     = 1'b1;
                    hit_mis[e] = exec[l].mispredict;
                    hit_pc[e]  = exec[l].pc;
                end
            end
        end
    end

    // Status flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resolved_mem <= '0;
            mispred_mem  <= '0;
        end else if (flush_all) begin
            resolved_mem <= '0;
            mispred_mem  <= '0;
        end else begin
            for (int e = 0; e < BUF_DEPTH; e++) begin
                if (hit[e]) begin
                    resolved_mem[e] <= 1'b1;
                    mispred_mem[e]  <= hit_mis[e];
                end
            end
            // A fresh push overrides any match on the same edge
            for (int l = 0; l < LANES; l++) begin
                if (wr_en[l]) begin
                    resolved_mem[wr_slot[l]] <= 1'b0;
                    mispred_mem[wr_slot[l]]  <= 1'b0;
                end
            end
        end
    end

    // Correct PC from the execute match and ROB id from the push
    always_ff @(posedge clk) begin
        for (int e = 0; e < BUF_DEPTH; e++) begin
            if (hit[e]) begin
                pc_mem[e] <= hit_pc[e];
            end
        end
        for (int l = 0; l < LANES; l++) begin
            if (wr_en[l]) begin
                rob_id_mem[wr_slot[l]] <= push[l].rob_id;
            end
        end
    end

    // ====================
    // Oldest window
    // ====================

    // Slots head, head+1, head+2 with index wrap
    always_comb begin
        logic [IDX_W-1:0] idx;
        for (int k = 0; k < LANES; k++) begin
            idx                  = head_idx + IDX_W'(k);
            window[k].present    = (count > CNT_W'(k));
            window[k].rob_id     = rob_id_mem[idx];
            window[k].resolved   = resolved_mem[idx];
            window[k].mispredict = mispred_mem[idx];
            window[k].pc         = pc_mem[idx];
        end
    end

endmodule

// ==== design/brb_resolve.sv ====
`timescale 1ns/1ns

module brb_resolve
    import brb_pkg::*;
(
    input  win_entry_t [LANES-1:0]    window,
    input  exec_lane_t [LANES-1:0]    exec,
    output resolve_lane_t [LANES-1:0] resolved,
    output logic [1:0]                pop_count,
    output logic                      flush_req
);

    // ====================
    // Same-cycle bypass
    // ====================

    // Stored status with any matching execute result laid over it
    resolve_lane_t [LANES-1:0] merged;

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            merged[k].resolved   = window[k].resolved;
            merged[k].mispredict = window[k].mispredict;
            merged[k].rob_id     = window[k].rob_id;
            merged[k].pc         = window[k].pc;
            // Top lane first so lane 0 overrides on a duplicate id
            for (int l = LANES - 1; l >= 0; l--) begin
                if (exec[l].valid && (exec[l].rob_id == window[k].rob_id)) begin
                    merged[k].resolved   = 1'b1;
                    merged[k].mispredict = exec[l].mispredict;
                    merged[k].pc         = exec[l].pc;
                end
            end
        end
    end

    // ====================
    // In-order reporting
    // ====================

    // Stop at the first unresolved slot or just after a mispredict
    always_comb begin
        logic chain_ok;
        chain_ok = 1'b1;
        for (int k = 0; k < LANES; k++) begin
            resolved[k] = '0;
            if (chain_ok && window[k].present && merged[k].resolved) begin
                resolved[k] = merged[k];
                if (merged[k].mispredict) begin
                    // Younger slots get flushed
                    chain_ok = 1'b0;
                end
            end else begin
                chain_ok = 1'b0;
            end
        end
    end

    // Retire count and flush request
    always_comb begin
        pop_count = '0;
        flush_req = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            if (resolved[k].resolved && !resolved[k].mispredict) begin
                pop_count = pop_count + 2'd1;
            end
            if (resolved[k].resolved && resolved[k].mispredict) begin
                flush_req = 1'b1;
            end
        end
    end

endmodule

// ==== design/brb_top.sv ====
`timescale 1ns/1ns

module brb_top
    import brb_pkg::*;
#(
    parameter int BUF_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  push_lane_t [LANES-1:0]      push,
    input  exec_lane_t [LANES-1:0]      exec,
    input  logic                        flush,
    output resolve_lane_t [LANES-1:0]   resolved,
    output logic [$clog2(BUF_DEPTH):0]  count,
    output logic                        full,
    output logic                        empty
);

    localparam int IDX_W = $clog2(BUF_DEPTH);

    // Internal wires between the units
    logic [IDX_W-1:0]            head_idx;
    logic [LANES-1:0]            wr_en;
    logic [LANES-1:0][IDX_W-1:0] wr_slot;
    logic [1:0]                  pop_count;
    logic                        flush_req;
    logic                        flush_all;
    win_entry_t [LANES-1:0]      window;

    // Storage clears on a mispredict or an external flush
    assign flush_all = flush_req | flush;

    // Pointers, occupancy and push slots
    brb_ptr_ctrl #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_ptr_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .pop_count (pop_count),
        .flush_req (flush_req),
        .flush     (flush),
        .head_idx  (head_idx),
        .wr_en     (wr_en),
        .wr_slot   (wr_slot),
        .count     (count),
        .full      (full),
        .empty     (empty)
    );

    // Entry arrays and execute match
    brb_entry_store #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_entry_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .wr_en     (wr_en),
        .wr_slot   (wr_slot),
        .exec      (exec),
        .flush_all (flush_all),
        .head_idx  (head_idx),
        .count     (count),
        .window    (window)
    );

    // Oldest-first resolution with bypass
    brb_resolve u_resolve (
        .window    (window),
        .exec      (exec),
        .resolved  (resolved),
        .pop_count (pop_count),
        .flush_req (flush_req)
    );

endmodule

// ==== bench/brb_assert.sv ====
`timescale 1ns/1ns

module brb_assert
    import brb_pkg::*;
(
    input logic                      clk,
    input logic                      rst_n,
    input resolve_lane_t [LANES-1:0] resolved,
    input logic                      full,
    input logic                      empty
);

    // Any reported lane carrying a mispredict
    logic any_mispredict;

    // Number of assertion failures so far
    int fail_count = 0;

    assign any_mispredict = (resolved[0].resolved && resolved[0].mispredict)
                         || (resolved[1].resolved && resolved[1].mispredict)
                         || (resolved[2].resolved && resolved[2].mispredict);

    // ====================
    // Output rules
    // ====================

    // Occupancy flags exclude each other
    a_full_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(full && empty))
        else begin
            $error("full and empty high together");
            fail_count++;
        end

    // Lane 1 only behind a clean lane 0
    a_lane1_order: assert property (@(posedge clk) disable iff (!rst_n)
        resolved[1].resolved |-> (resolved[0].resolved && !resolved[0].mispredict))
        else begin
            $error("lane 1 reported out of order");
            fail_count++;
        end

    // Lane 2 only behind clean lanes 0 and 1
    a_lane2_order: assert property (@(posedge clk) disable iff (!rst_n)
        resolved[2].resolved |-> (resolved[1].resolved && !resolved[1].mispredict
                               && resolved[0].resolved && !resolved[0].mispredict))
        else begin
            $error("lane 2 reported out of order");
            fail_count++;
        end

    // Mispredict flushes everything by the next edge
    a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
        any_mispredict |=> empty)
        else begin
            $error("buffer not empty after a mispredict");
            fail_count++;
        end

endmodule

bind brb_top brb_assert u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .resolved (resolved),
    .full     (full),
    .empty    (empty)
);

// ==== bench/brb_tb.sv ====
`timescale 1ns/1ns

module brb_tb
    import brb_pkg::*;
();

    localparam int    BUF_DEPTH   = 16;
    localparam int    CNT_W       = $clog2(BUF_DEPTH) + 1;
    localparam int    PERIOD      = 40;
    localparam int    SKEW        = 2;
    localparam int    RST_CYCLES  = 8;
    localparam string GOLDEN_FILE = "bench/brb_golden.txt";

    // One golden line with stimulus first and expected outputs after it
    typedef struct packed {
        logic [7:0]                test;
        push_lane_t [LANES-1:0]    push;
        exec_lane_t [LANES-1:0]    exec;
        logic                      flush;
        resolve_lane_t [LANES-1:0] res;
        logic [CNT_W-1:0]          count;
        logic                      full;
        logic                      empty;
    } golden_row_t;

    logic                      clk;
    logic                      rst_n;
    push_lane_t [LANES-1:0]    push;
    exec_lane_t [LANES-1:0]    exec;
    logic                      flush;
    resolve_lane_t [LANES-1:0] resolved;
    logic [CNT_W-1:0]          count;
    logic                      full;
    logic                      empty;

    golden_row_t rows[$];
    int          row_total;
    int          cur_row;
    // Mismatches inside the running test
    int          errors;
    int          tests_ok;
    int          tests_bad;
    bit          load_ok;

    brb_top #(
        .BUF_DEPTH (BUF_DEPTH)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .exec     (exec),
        .flush    (flush),
        .resolved (resolved),
        .count    (count),
        .full     (full),
        .empty    (empty)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    // ====================
    // Golden file
    // ====================

    task automatic load_golden(output bit ok);
        int              fd;
        int              n;
        int              t;
        int              cnt;
        int              fl;
        int              fu;
        int              em;
        string           line;
        logic [2:0]      pmask;
        logic [2:0]      emask;
        logic [2:0]      emis;
        logic [2:0]      rmask;
        logic [2:0]      rmis;
        int              pid [LANES];
        int              eid [LANES];
        int              rid [LANES];
        logic [PC_W-1:0] epc [LANES];
        logic [PC_W-1:0] rpc [LANES];
        golden_row_t     row;
        ok = 1'b0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            return;
        end
        ok = 1'b1;
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // Blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%d %b %d %d %d %b %b %d %d %d %h %h %h %d %b %b %d %d %d %h %h %h %d %d %d",
                t, pmask, pid[0], pid[1], pid[2],
                emask, emis, eid[0], eid[1], eid[2], epc[0], epc[1], epc[2], fl,
                rmask, rmis, rid[0], rid[1], rid[2], rpc[0], rpc[1], rpc[2], cnt, fu, em);
            if (n != 25) begin
                $display("malformed golden line: %s", line);
                ok = 1'b0;
                break;
            end
            row      = '0;
            row.test = 8'(t);
            for (int k = 0; k < LANES; k++) begin
                row.push[k].valid      = pmask[k];
                row.push[k].rob_id     = ROB_ID_W'(pid[k]);
                row.exec[k].valid      = emask[k];
                row.exec[k].mispredict = emis[k];
                row.exec[k].rob_id     = ROB_ID_W'(eid[k]);
                row.exec[k].pc         = epc[k];
                row.res[k].resolved    = rmask[k];
                row.res[k].mispredict  = rmis[k];
                row.res[k].rob_id      = ROB_ID_W'(rid[k]);
                row.res[k].pc          = rpc[k];
            end
            row.flush = fl[0];
            row.count = CNT_W'(cnt);
            row.full  = fu[0];
            row.empty = em[0];
            rows.push_back(row);
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            ok = 1'b0;
        end
    endtask

    // ====================
    // Drive and compare
    // ====================

    task automatic drive_row(input golden_row_t row);
        push  = row.push;
        exec  = row.exec;
        flush = row.flush;
        // Idle lanes in test 2 carry random ids that the DUT must ignore
        if (row.test == 8'd2) begin
            for (int k = 0; k < LANES; k++) begin
                if (!row.push[k].valid) begin
                    push[k].rob_id = ROB_ID_W'($urandom);
                end
                if (!row.exec[k].valid) begin
                    exec[k].rob_id = ROB_ID_W'($urandom);
                end
            end
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: row %0d %s", $time, cur_row, msg);
        errors++;
    endtask

    task automatic check_row(input golden_row_t row);
        for (int k = 0; k < LANES; k++) begin
            if (resolved[k].resolved !== row.res[k].resolved) begin
                report_mismatch($sformatf("lane %0d resolved got %b exp %b",
                    k, resolved[k].resolved, row.res[k].resolved));
            end
            if (resolved[k].mispredict !== row.res[k].mispredict) begin
                report_mismatch($sformatf("lane %0d mispredict got %b exp %b",
                    k, resolved[k].mispredict, row.res[k].mispredict));
            end
            if (resolved[k].rob_id !== row.res[k].rob_id) begin
                report_mismatch($sformatf("lane %0d rob_id got %0d exp %0d",
                    k, resolved[k].rob_id, row.res[k].rob_id));
            end
            if (resolved[k].pc !== row.res[k].pc) begin
                report_mismatch($sformatf("lane %0d pc got %h exp %h",
                    k, resolved[k].pc, row.res[k].pc));
            end
        end
        if (count !== row.count) begin
            report_mismatch($sformatf("count got %0d exp %0d", count, row.count));
        end
        if (full !== row.full) begin
            report_mismatch($sformatf("full got %b exp %b", full, row.full));
        end
        if (empty !== row.empty) begin
            report_mismatch($sformatf("empty got %b exp %b", empty, row.empty));
        end
    endtask

    task automatic close_test(input int test_no);
        if (errors == 0) begin
            $display("[test %0d] ok", test_no);
            tests_ok++;
        end else begin
            $display("[test %0d] %0d mismatches", test_no, errors);
            tests_bad++;
        end
        errors = 0;
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        golden_row_t row;
        int          cur_test;
        rst_n     = 1'b0;
        push      = '0;
        exec      = '0;
        flush     = 1'b0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        row_total = 0;
        cur_row   = 0;
        void'($urandom(7506));
        load_golden(load_ok);
        if (!load_ok) begin
            $display("golden file %s is missing, unreadable or malformed", GOLDEN_FILE);
        end else begin
            row_total = rows.size();
            repeat (RST_CYCLES) @(posedge clk);
            #SKEW;
            rst_n    = 1'b1;
            cur_test = int'(rows[0].test);
            for (int i = 0; i < row_total; i++) begin
                row = rows[i];
                if (int'(row.test) != cur_test) begin
                    close_test(cur_test);
                    cur_test = int'(row.test);
                end
                cur_row = i;
                drive_row(row);
                // Outputs settle well before the next rising edge
                #(PERIOD - 2 * SKEW);
                check_row(row);
                @(posedge clk);
                #SKEW;
            end
            close_test(cur_test);
        end
        $display("summary: %0d tests ok, %0d tests with mismatches, %0d assertion failures",
            tests_ok, tests_bad, dut_i.u_assert.fail_count);
        if (load_ok && tests_bad == 0 && dut_i.u_assert.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the golden line count
    initial begin
        wait (row_total > 0);
        #((row_total + 20) * PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", row_total + 20);
        $display("test failed");
        $finish;
    end

endmodule

// ==== src.f ====
design/brb_pkg.sv
design/brb_ptr_ctrl.sv
design/brb_entry_store.sv
design/brb_resolve.sv
design/brb_top.sv
bench/brb_assert.sv
bench/brb_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = brb_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/brb_golden.txt ====
# test | push: mask id0 id1 id2 | exec: mask mis id0 id1 id2 pc0 pc1 pc2 | flush
#      | expect: mask mis id0 id1 id2 pc0 pc1 pc2 | count full empty
# Masks binary with lane 0 rightmost, ids decimal, pcs hex, one line per cycle
# Test 1: state after reset
1 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        0 0 1
1 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        0 0 1
# Test 2: fill to full, oversized groups dropped
2 111 1 2 3    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        0 0 1
2 111 4 5 6    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        3 0 0
2 111 7 8 9    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        6 0 0
2 111 10 11 12 000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        9 0 0
2 101 13 0 14  000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        12 0 0
2 111 16 17 18 000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        14 0 0
2 011 15 16 0  000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        14 0 0
2 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        16 1 0
2 100 0 0 20   000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        16 1 0
2 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        16 1 0
# Test 3: deep results in reverse age, reported as the head arrives
3 000 0 0 0    111 000 6 5 4 600 500 400    0  000 000 0 0 0 0 0 0        16 1 0
3 000 0 0 0    011 000 3 2 0 300 200 0      0  000 000 0 0 0 0 0 0        16 1 0
3 000 0 0 0    001 000 1 0 0 100 0 0        0  111 000 1 2 3 100 200 300  16 1 0
3 000 0 0 0    000 000 0 0 0 0 0 0          0  111 000 4 5 6 400 500 600  13 0 0
3 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        10 0 0
# Test 4: bypass for the oldest entry, lane 0 wins a duplicate id
4 000 0 0 0    011 010 7 7 0 700 7ff 0      0  001 000 7 0 0 700 0 0      10 0 0
4 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        9 0 0
# Test 5: mispredict on the second oldest, push in that cycle dropped
5 001 30 0 0   111 010 8 9 10 800 900 a00   0  011 010 8 9 0 800 900 0    9 0 0
5 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        0 0 1
# Test 6: external flush, stored results gone after refill
6 111 21 22 23 000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        0 0 1
6 001 24 0 0   001 000 22 0 0 220 0 0       0  000 000 0 0 0 0 0 0        3 0 0
6 001 25 0 0   001 000 24 0 0 240 0 0       1  000 000 0 0 0 0 0 0        4 0 0
6 111 41 42 43 000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        0 0 1
6 001 44 0 0   000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        3 0 0
6 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        4 0 0
6 000 0 0 0    001 000 41 0 0 410 0 0       0  001 000 41 0 0 410 0 0     4 0 0
6 000 0 0 0    000 000 0 0 0 0 0 0          0  000 000 0 0 0 0 0 0        3 0 0
